//--- design/lcd_pkg.sv
package lcd_pkg;

	// time base, kept small for simulation
	localparam int us_cycles   = 2;   // clocks per microsecond
	localparam int power_up_us = 500; // wait after supply is stable
	localparam int e_setup_us  = 1;   // data valid to rising enable
	localparam int e_high_us   = 13;  // enable pulse width
	localparam int cmd_us      = 50;  // total time of a normal command
	localparam int long_cmd_us = 200; // clear and home

	localparam int power_up_cyc = power_up_us * us_cycles;
	localparam int e_setup_cyc  = e_setup_us * us_cycles;
	localparam int e_high_cyc   = e_high_us * us_cycles;
	localparam int cmd_cyc      = cmd_us * us_cycles;
	localparam int long_cmd_cyc = long_cmd_us * us_cycles;

	// sized by the longest interval, the power-up wait
	localparam int cnt_w = $clog2(power_up_cyc + 1);

	// host command queue
	localparam int queue_depth = 4;
	localparam int q_ptr_w     = $clog2(queue_depth);
	localparam int q_cnt_w     = $clog2(queue_depth + 1);

	// init sequence length and config word width
	localparam int init_len = 4;
	localparam int cfg_w    = 7;

	// instruction base bytes
	localparam logic [7:0] cmd_function_set = 8'h30; // 8-bit bus
	localparam logic [7:0] cmd_display_ctrl = 8'h08;
	localparam logic [7:0] cmd_clear        = 8'h01;
	localparam logic [7:0] cmd_home         = 8'h02;
	localparam logic [7:0] cmd_entry_mode   = 8'h04;

	// bit positions in cfg
	localparam int cfg_lines   = 6;
	localparam int cfg_font    = 5;
	localparam int cfg_display = 4;
	localparam int cfg_cursor  = 3;
	localparam int cfg_blink   = 2;
	localparam int cfg_inc     = 1;
	localparam int cfg_shift   = 0;

	typedef struct packed {
		logic       rs;   // 0 instruction, 1 data
		logic [7:0] data;
	} lcd_cmd_t;

	// clear and home need the long execution time
	function automatic logic is_long_cmd(input lcd_cmd_t c);
		return !c.rs && (c.data == cmd_clear || c.data == cmd_home);
	endfunction

endpackage

//--- design/lcd_cmd_if.sv
`timescale 1ns/1ps

// one command per valid cycle, one credit pulse per freed slot
interface lcd_cmd_if (
	input logic clk
);
	import lcd_pkg::*;

	logic     valid;  // single-cycle, only while a credit is held
	lcd_cmd_t cmd;
	logic     credit; // single-cycle return

	modport src (
		input  clk,
		output valid,
		output cmd,
		input  credit
	);

	modport snk (
		input  clk,
		input  valid,
		input  cmd,
		output credit
	);

endinterface

//--- design/lcd_cmd_queue.sv
`timescale 1ns/1ps

module lcd_cmd_queue (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cmd_valid,
	input  logic       cmd_rs,
	input  logic [7:0] cmd_data,
	output logic       cmd_credit,
	lcd_cmd_if.src     down
);
	import lcd_pkg::*;

	lcd_cmd_t           mem [queue_depth];
	logic [q_ptr_w-1:0] wr_ptr;
	logic [q_ptr_w-1:0] rd_ptr;
	logic [q_cnt_w-1:0] count;
	logic               dn_credit; // one slot in the sequencer
	logic               dn_avail;
	logic               pop;

	// a credit returned this cycle can be spent right away
	assign dn_avail = dn_credit | down.credit;
	assign pop      = dn_avail && (count != '0);

	// each pop frees one slot for the host
	assign cmd_credit = pop;

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			mem[wr_ptr] <= '{rs: cmd_rs, data: cmd_data};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({cmd_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// downstream credit, starts with one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dn_credit <= 1'b1;
		end else begin
			dn_credit <= dn_avail & ~pop;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			down.valid <= 1'b0;
		end else begin
			down.valid <= pop;
		end
	end

	// head goes out the cycle after the pop
	always_ff @(posedge clk) begin
		if (pop) begin
			down.cmd <= mem[rd_ptr];
		end
	end

endmodule

//--- design/lcd_init_sequencer.sv
`timescale 1ns/1ps

module lcd_init_sequencer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [lcd_pkg::cfg_w-1:0] cfg,
	output logic                      ready,
	lcd_cmd_if.snk                    up,
	lcd_cmd_if.src                    down
);
	import lcd_pkg::*;

	typedef enum logic [1:0] {
		ph_power,
		ph_init,
		ph_run
	} phase_t;

	phase_t           phase;
	logic [cnt_w-1:0] pwr_cnt;
	logic [2:0]       idx;       // next init command, init_len when done
	logic [cfg_w-1:0] cfg_q;
	logic             dn_credit;
	logic             dn_avail;
	logic             hold_valid; // command parked from up
	lcd_cmd_t         hold_cmd;
	logic             send;
	lcd_cmd_t         send_cmd;
	logic             pop_hold;
	logic             bypass;    // up command goes straight through

	function automatic logic [7:0] init_byte(input logic [1:0] i, input logic [cfg_w-1:0] c);
		logic [7:0] b;
		case (i)
			2'd0:    b = cmd_function_set | {4'b0, c[cfg_lines], c[cfg_font], 2'b0};
			2'd1:    b = cmd_display_ctrl | {5'b0, c[cfg_display], c[cfg_cursor], c[cfg_blink]};
			2'd2:    b = cmd_clear;
			default: b = cmd_entry_mode | {6'b0, c[cfg_inc], c[cfg_shift]};
		endcase
		return b;
	endfunction

	assign dn_avail = dn_credit | down.credit;
	assign ready    = (phase == ph_run);

	always_comb begin
		send     = 1'b0;
		send_cmd = '{rs: 1'b0, data: init_byte(idx[1:0], cfg_q)};
		pop_hold = 1'b0;
		bypass   = 1'b0;
		case (phase)
			ph_init: begin
				send = dn_avail && (idx < 3'(init_len));
			end
			ph_run: begin
				if (hold_valid && dn_avail) begin
					send     = 1'b1;
					send_cmd = hold_cmd;
					pop_hold = 1'b1;
				end else if (up.valid && dn_avail) begin
					send     = 1'b1;
					send_cmd = up.cmd;
					bypass   = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase   <= ph_power;
			pwr_cnt <= '0;
			idx     <= '0;
		end else begin
			case (phase)
				ph_power: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (pwr_cnt == cnt_w'(power_up_cyc - 1)) begin
						phase <= ph_init;
					end
				end
				ph_init: begin
					if (send) begin
						idx <= idx + 1'b1;
					end
					// entry mode finished in the driver
					if (idx == 3'(init_len) && down.credit) begin
						phase <= ph_run;
					end
				end
				default: ;
			endcase
		end
	end

	// config is read once, at the end of power-up
	always_ff @(posedge clk) begin
		if (phase == ph_power && pwr_cnt == cnt_w'(power_up_cyc - 1)) begin
			cfg_q <= cfg;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dn_credit  <= 1'b1;
			hold_valid <= 1'b0;
			down.valid <= 1'b0;
			up.credit  <= 1'b0;
		end else begin
			dn_credit  <= dn_avail & ~send;
			hold_valid <= (hold_valid & ~pop_hold) | (up.valid & ~bypass);
			down.valid <= send;
			up.credit  <= pop_hold | bypass; // slot free once forwarded
		end
	end

	always_ff @(posedge clk) begin
		if (up.valid && !bypass) begin
			hold_cmd <= up.cmd;
		end
		if (send) begin
			down.cmd <= send_cmd;
		end
	end

endmodule

//--- design/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver (
	input  logic       clk,
	input  logic       rst_n,
	lcd_cmd_if.snk     up,
	output logic       lcd_e,
	output logic       lcd_rs,
	output logic [7:0] lcd_data
);
	import lcd_pkg::*;

	logic             busy;
	logic [cnt_w-1:0] cnt;      // cycles since accept, 1 on the first busy cycle
	logic             long_q;   // clear or home in flight
	logic [cnt_w-1:0] last_cnt;
	logic             e_nxt;
	logic             done;

	// total command time less one, credit is registered
	always_comb begin
		if (long_q) begin
			last_cnt = cnt_w'(long_cmd_cyc - 1);
		end else begin
			last_cnt = cnt_w'(cmd_cyc - 1);
		end
	end

	assign done = busy && (cnt == last_cnt);

	// enable window, decoded one cycle ahead so lcd_e is a flop
	always_comb begin
		e_nxt = 1'b0;
		if (busy) begin
			e_nxt = (cnt >= cnt_w'(e_setup_cyc)) &&
				(cnt < cnt_w'(e_setup_cyc + e_high_cyc));
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			cnt    <= '0;
			long_q <= 1'b0;
		end else begin
			if (!busy) begin
				if (up.valid) begin
					busy   <= 1'b1;
					cnt    <= cnt_w'(1);
					long_q <= is_long_cmd(up.cmd);
				end
			end else if (done) begin
				busy <= 1'b0;
				cnt  <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// bus lines, held from accept through the hold time
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lcd_rs   <= 1'b0;
			lcd_data <= '0;
		end else begin
			if (!busy && up.valid) begin
				lcd_rs   <= up.cmd.rs;
				lcd_data <= up.cmd.data;
			end else if (done) begin
				lcd_rs   <= 1'b0; // park low when idle
				lcd_data <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lcd_e <= 1'b0;
		end else begin
			lcd_e <= e_nxt;
		end
	end

	// execution time elapsed, stands in for busy-flag polling
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			up.credit <= 1'b0;
		end else begin
			up.credit <= done;
		end
	end

endmodule

//--- design/lcd_subsystem.sv
`timescale 1ns/1ps

module lcd_subsystem (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [lcd_pkg::cfg_w-1:0] cfg,
	input  logic                      cmd_valid,
	input  logic                      cmd_rs,
	input  logic [7:0]                cmd_data,
	output logic                      cmd_credit,
	output logic                      ready,
	output logic                      lcd_e,
	output logic                      lcd_rs,
	output logic [7:0]                lcd_data
);

	// queue to sequencer, one credit
	lcd_cmd_if q2s (
		.clk(clk)
	);

	// sequencer to driver, one credit
	lcd_cmd_if s2d (
		.clk(clk)
	);

	lcd_cmd_queue u_cmd_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_rs    (cmd_rs),
		.cmd_data  (cmd_data),
		.cmd_credit(cmd_credit),
		.down      (q2s.src)
	);

	lcd_init_sequencer u_init_sequencer (
		.clk  (clk),
		.rst_n(rst_n),
		.cfg  (cfg),
		.ready(ready),
		.up   (q2s.snk),
		.down (s2d.src)
	);

	lcd_bus_driver u_bus_driver (
		.clk     (clk),
		.rst_n   (rst_n),
		.up      (s2d.snk),
		.lcd_e   (lcd_e),
		.lcd_rs  (lcd_rs),
		.lcd_data(lcd_data)
	);

endmodule

//--- sim/lcd_assertions.sv
`timescale 1ns/1ps

module lcd_assertions (
	input logic       clk,
	input logic       rst_n,
	input logic       cmd_credit,
	input logic       ready,
	input logic       lcd_e,
	input logic       lcd_rs,
	input logic [7:0] lcd_data
);
	import lcd_pkg::*;

	int   cyc;       // cycles since reset release
	int   gap;       // cycles since the last enable rise
	int   hi_len;    // enable high time so far
	int   n_rise;
	logic e_q;
	logic last_long; // previous write was clear or home
	int   fail_cnt = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cyc       <= 0;
			gap       <= 0;
			hi_len    <= 0;
			n_rise    <= 0;
			e_q       <= 1'b0;
			last_long <= 1'b0;
		end else begin
			if (cyc < power_up_cyc) begin
				cyc <= cyc + 1;
			end
			e_q    <= lcd_e;
			hi_len <= lcd_e ? hi_len + 1 : 0;
			if (lcd_e && !e_q) begin
				gap       <= 1;
				n_rise    <= n_rise + 1;
				last_long <= is_long_cmd({lcd_rs, lcd_data});
			end else if (gap < long_cmd_cyc) begin
				gap <= gap + 1; // saturates at the long command time
			end
		end
	end

	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		cyc < power_up_cyc |-> !lcd_e && !ready && !cmd_credit)
		else begin
			fail_cnt++;
			$error("outputs became active during the power-up wait");
		end

	// expected head is kept by the testbench
	a_value: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(lcd_e) |-> tb_lcd.exp_cnt != 0 && {lcd_rs, lcd_data} == tb_lcd.exp_bus)
		else begin
			fail_cnt++;
			$error("** Error lcd_rs,lcd_data exp=%h got=%h", tb_lcd.exp_bus, {lcd_rs, lcd_data});
		end

	a_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(lcd_e) |-> hi_len == e_high_cyc)
		else begin
			fail_cnt++;
			$error("** Error lcd_e width exp=%h got=%h", e_high_cyc, hi_len);
		end

	a_setup: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(lcd_e) |-> $past({lcd_rs, lcd_data}, e_setup_cyc) == {lcd_rs, lcd_data})
		else begin
			fail_cnt++;
			$error("bus lines changed inside the setup time before enable");
		end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_e |-> $stable({lcd_rs, lcd_data}))
		else begin
			fail_cnt++;
			$error("bus lines changed while enable was high");
		end

	a_space: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(lcd_e) && n_rise != 0 |-> gap >= (last_long ? long_cmd_cyc : cmd_cyc))
		else begin
			fail_cnt++;
			$error("enable rising edges closer than the command time");
		end

	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ready) |-> n_rise == init_len && gap >= cmd_cyc - e_setup_cyc)
		else begin
			fail_cnt++;
			$error("ready rose before the init sequence had finished");
		end

	a_credit: assert property (@(posedge clk) disable iff (!rst_n)
		tb_lcd.returned <= tb_lcd.sent)
		else begin
			fail_cnt++;
			$error("cmd_credit pulsed with no command outstanding");
		end

endmodule

//--- sim/tb_lcd.sv
`timescale 1ns/1ps

module tb_lcd;
	import lcd_pkg::*;

	localparam int n_host = 10; // more than queue_depth, so the host stalls
	localparam int wd_cyc = power_up_cyc + (init_len + n_host) * (long_cmd_cyc + 4) + 500;

	logic             clk;
	logic             rst_n;
	logic [cfg_w-1:0] cfg;
	logic             cmd_valid;
	logic             cmd_rs;
	logic [7:0]       cmd_data;
	logic             cmd_credit;
	logic             ready;
	logic             lcd_e;
	logic             lcd_rs;
	logic [7:0]       lcd_data;

	logic [31:0] seed;
	lcd_cmd_t    exp_q[$];  // bus writes still to come
	lcd_cmd_t    host_q[$]; // host commands not yet sent
	lcd_cmd_t    exp_bus;
	int          exp_cnt;
	int          credits;
	int          sent;
	int          returned;
	int          tb_errs;
	int          timeouts;
	logic        e_prev;

	lcd_subsystem u_lcd_subsystem (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.cmd_valid (cmd_valid),
		.cmd_rs    (cmd_rs),
		.cmd_data  (cmd_data),
		.cmd_credit(cmd_credit),
		.ready     (ready),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_data  (lcd_data)
	);

	bind lcd_subsystem lcd_assertions u_assertions (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_credit(cmd_credit),
		.ready     (ready),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_data  (lcd_data)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// HD44780 bit layout of the four init instructions
	function automatic lcd_cmd_t init_write(input int i, input logic [cfg_w-1:0] c);
		lcd_cmd_t w;
		w.rs = 1'b0;
		case (i)
			0:       w.data = 8'h30 | (8'(c[6]) << 3) | (8'(c[5]) << 2); // N and F
			1:       w.data = 8'h08 | (8'(c[4]) << 2) | (8'(c[3]) << 1) | 8'(c[2]);
			2:       w.data = 8'h01;
			default: w.data = 8'h04 | (8'(c[1]) << 1) | 8'(c[0]); // I/D and S
		endcase
		return w;
	endfunction

	task automatic load_head();
		exp_cnt = exp_q.size();
		if (exp_cnt != 0) begin
			exp_bus = exp_q[0];
		end
	endtask

	task automatic finish_run();
		int a_fails;
		a_fails = u_lcd_subsystem.u_assertions.fail_cnt;
		$display("errors: %0d assertion failures, %0d testbench checks, %0d timeouts",
			a_fails, tb_errs, timeouts);
		if (a_fails + tb_errs + timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	initial begin
		#(wd_cyc * 20);
		timeouts++;
		$display("watchdog expired with %0d bus writes and %0d credits still pending",
			exp_cnt, sent - returned);
		finish_run();
	end

	// a write retires when its enable pulse ends
	always @(negedge clk) begin
		if (e_prev && !lcd_e && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			load_head();
		end
		e_prev = lcd_e;
	end

	initial begin
		lcd_cmd_t c;
		rst_n     = 1'b0;
		cmd_valid = 1'b0;
		cmd_rs    = 1'b0;
		cmd_data  = '0;
		e_prev    = 1'b0;
		credits   = queue_depth;
		sent      = 0;
		returned  = 0;
		tb_errs   = 0;
		timeouts  = 0;
		seed      = xorshift(32'ha047);
		cfg       = seed[cfg_w-1:0];
		for (int i = 0; i < init_len; i++) begin
			exp_q.push_back(init_write(i, cfg));
		end
		host_q.push_back('{rs: 1'b0, data: 8'h01}); // clear, then data at long spacing
		for (int i = 1; i < n_host; i++) begin
			seed   = xorshift(seed);
			c.rs   = seed[9] | seed[10]; // mostly data writes
			c.data = seed[7:0];
			if (i == n_host / 2) begin
				c = '{rs: 1'b0, data: 8'h02}; // return home
			end
			host_q.push_back(c);
		end
		foreach (host_q[i]) begin
			exp_q.push_back(host_q[i]);
		end
		load_head();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		while (!ready) begin
			@(negedge clk);
		end
		while (host_q.size() != 0 || sent != returned || exp_cnt != 0) begin
			if (host_q.size() != 0 && credits > 0) begin
				c         = host_q.pop_front();
				cmd_valid = 1'b1;
				cmd_rs    = c.rs;
				cmd_data  = c.data;
				credits--;
				sent++;
			end else begin
				cmd_valid = 1'b0;
			end
			if (cmd_credit) begin // usable from the next cycle
				credits++;
				returned++;
			end
			@(negedge clk);
		end
		cmd_valid = 1'b0;
		// every credit is back, so any further pulse is one too many
		repeat (10) begin
			if (cmd_credit) begin
				returned++;
			end
			@(negedge clk);
		end
		if (returned != sent) begin
			tb_errs++;
			$display("** Error cmd_credit pulses exp=%h got=%h", sent, returned);
		end
		finish_run();
	end

endmodule

//--- src.f
design/lcd_pkg.sv
design/lcd_cmd_if.sv
design/lcd_cmd_queue.sv
design/lcd_init_sequencer.sv
design/lcd_bus_driver.sv
design/lcd_subsystem.sv
sim/lcd_assertions.sv
sim/tb_lcd.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f src.f --top-module tb_lcd -o sim_lcd \
	&& ./obj_dir/sim_lcd +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -q "ALL TESTS PASSED" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
